/* src/cgra_rd_pkg.sv */
package cgra_rd_pkg;

    // Node count and buffering
    localparam int unsigned NODES_NUM       = 4;
    localparam int unsigned MAX_OUTSTANDING = 4;
    localparam int unsigned NODE_FIFO_DEPTH = 10;

    // Datapath widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned WORD_W = 32;
    localparam int unsigned BUS_W  = 64;
    localparam int unsigned LEN_W  = 16;

    // Node FIFO usage counts 0 to NODE_FIFO_DEPTH inclusive
    localparam int unsigned NODE_USAGE_W = $clog2(NODE_FIFO_DEPTH + 1);

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [BUS_W-1:0]     bus_t;
    typedef logic [LEN_W-1:0]     len_t;
    typedef logic [NODES_NUM-1:0] node_mask_t;

    // One entry per read in flight
    typedef struct packed {
        node_mask_t node;
        logic       upper_half;
    } trans_info_t;

    // Read-address channel
    typedef enum logic {
        AR_IDLE,
        AR_WAIT
    } ar_state_e;

endpackage

/* src/rr_arbiter.sv */
module rr_arbiter import cgra_rd_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  node_mask_t request_i,
    input  logic       enable_i,
    output node_mask_t grant_o
);

    // One-hot position with highest priority for the next grant
    node_mask_t ptr_q;

    logic [2*NODES_NUM-1:0] req_dbl;
    logic [2*NODES_NUM-1:0] gnt_dbl;

    // Subtracting the pointer clears the first request at or above it
    // The doubled vector covers the wrap back to node 0
    always_comb begin
        req_dbl = {request_i, request_i};
        gnt_dbl = req_dbl & ~(req_dbl - {{NODES_NUM{1'b0}}, ptr_q});
        grant_o = '0;
        if (enable_i) begin
            grant_o = gnt_dbl[NODES_NUM-1:0] | gnt_dbl[2*NODES_NUM-1:NODES_NUM];
        end
    end

    // Next priority goes to the node after the winner
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= node_mask_t'(1);
        end else if (|grant_o) begin
            ptr_q <= {grant_o[NODES_NUM-2:0], grant_o[NODES_NUM-1]};
        end
    end

endmodule

/* src/node_addr_gen.sv */
module node_addr_gen import cgra_rd_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  addr_t                   base_addr_i,
    input  len_t                    size_i,
    input  len_t                    stride_i,
    input  logic [NODE_USAGE_W-1:0] fifo_usage_i,
    input  logic                    grant_i,
    input  logic                    run_end_i,
    input  logic                    running_i,
    output logic                    request_o,
    output logic                    pending_o,
    output addr_t                   rd_addr_o
);

    // Byte offset from the base that is wide enough to step past size
    addr_t offset_q;

    logic offsets_left;
    logic fifo_room;

    assign offsets_left = offset_q < ADDR_W'(size_i);

    // Room for every reply that could still be in flight
    assign fifo_room = fifo_usage_i < NODE_USAGE_W'(NODE_FIFO_DEPTH - MAX_OUTSTANDING);

    // Still has work whether or not the FIFO has room
    assign pending_o = running_i && offsets_left;

    assign request_o = pending_o && fifo_room;

    assign rd_addr_o = base_addr_i + offset_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            offset_q <= '0;
        end else if (run_end_i) begin
            offset_q <= '0;
        end else if (grant_i) begin
            offset_q <= offset_q + ADDR_W'(stride_i);
        end
    end

endmodule

/* src/sync_fifo.sv */
module sync_fifo import cgra_rd_pkg::*; #(
    parameter int unsigned DEPTH = NODE_FIFO_DEPTH,
    parameter int unsigned WIDTH = WORD_W
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         push_i,
    input  logic                         pop_i,
    input  logic [WIDTH-1:0]             data_i,
    output logic [WIDTH-1:0]             data_o,
    output logic                         full_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   usage_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    logic do_push;
    logic do_pop;

    assign full_o  = 32'(count_q) == DEPTH;
    assign empty_o = count_q == '0;
    assign usage_o = count_q;
    assign data_o  = mem_q[rd_ptr_q];

    // A full FIFO still takes a push when it pops in the same cycle
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (32'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (32'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* src/read_channel_ctrl.sv */
module read_channel_ctrl import cgra_rd_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       execute_i,
    input  logic       any_request_i,
    input  node_mask_t grant_i,
    input  addr_t      node_addr_i [NODES_NUM],
    output logic       arb_enable_o,
    output logic       running_o,
    output logic       run_end_o,
    output logic       busy_o,
    output addr_t      m_ar_addr_o,
    output logic       m_ar_valid_o,
    input  logic       m_ar_ready_i,
    input  bus_t       m_r_data_i,
    input  logic       m_r_valid_i,
    output word_t      beat_word_o,
    output node_mask_t node_push_o
);

    logic      run_q;
    logic      run_d;
    ar_state_e ar_state_q;
    ar_state_e ar_state_d;
    addr_t     ar_addr_q;
    addr_t     grant_addr;

    logic ar_free;
    logic new_trans;

    trans_info_t outst_in;
    trans_info_t outst_head;
    logic        outst_full;
    logic        outst_empty;

    // Run ends once no node has work left and every read has returned
    always_comb begin
        run_d = run_q;
        if (execute_i) begin
            run_d = 1'b1;
        end else if (run_q && !any_request_i && outst_empty) begin
            run_d = 1'b0;
        end
    end

    // Generators may already request in the execute cycle
    assign running_o = run_q | execute_i;
    assign run_end_o = run_q & ~run_d;
    assign busy_o    = run_q;

    // Channel is free when idle or when the pending address is taken now
    assign ar_free      = (ar_state_q == AR_IDLE) || m_ar_ready_i;
    assign arb_enable_o = ar_free && !outst_full;
    assign new_trans    = |grant_i;

    always_comb begin
        ar_state_d = ar_state_q;
        if (ar_free) begin
            ar_state_d = new_trans ? AR_WAIT : AR_IDLE;
        end
    end

    // Grant is one-hot, so at most one address gets through
    always_comb begin
        grant_addr = '0;
        for (int unsigned i = 0; i < NODES_NUM; i++) begin
            if (grant_i[i]) begin
                grant_addr = node_addr_i[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q      <= 1'b0;
            ar_state_q <= AR_IDLE;
        end else begin
            run_q      <= run_d;
            ar_state_q <= ar_state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_trans) begin
            ar_addr_q <= grant_addr;
        end
    end

    // Bus is 64 bits wide, so the address is beat aligned
    assign m_ar_addr_o  = {ar_addr_q[ADDR_W-1:3], 3'b000};
    assign m_ar_valid_o = ar_state_q == AR_WAIT;

    // Bit 2 picks the 32-bit half inside the beat
    assign outst_in.node       = grant_i;
    assign outst_in.upper_half = grant_addr[2];

    sync_fifo #(
        .DEPTH (MAX_OUTSTANDING),
        .WIDTH ($bits(trans_info_t))
    ) u_outst_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (new_trans),
        .pop_i   (m_r_valid_i),
        .data_i  (outst_in),
        .data_o  (outst_head),
        .full_o  (outst_full),
        .empty_o (outst_empty),
        .usage_o ()
    );

    // Beats come back in request order so the FIFO head names the owner
    assign beat_word_o = outst_head.upper_half ? m_r_data_i[BUS_W-1:WORD_W]
                                               : m_r_data_i[WORD_W-1:0];
    assign node_push_o = m_r_valid_i ? outst_head.node : '0;

endmodule

/* src/cgra_read_dma.sv */
module cgra_read_dma import cgra_rd_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,

    // Run control
    input  logic       execute_i,
    output logic       busy_o,
    input  addr_t      base_addr_i [NODES_NUM],
    input  len_t       size_i [NODES_NUM],
    input  len_t       stride_i [NODES_NUM],

    // CGRA input nodes
    output word_t      node_data_o [NODES_NUM],
    output node_mask_t node_valid_o,
    input  node_mask_t node_ready_i,

    // Memory read channel
    output addr_t      m_ar_addr_o,
    output logic       m_ar_valid_o,
    input  logic       m_ar_ready_i,
    input  bus_t       m_r_data_i,
    input  logic       m_r_valid_i
);

    node_mask_t node_request;
    node_mask_t node_pending;
    node_mask_t node_grant;
    node_mask_t node_push;
    node_mask_t node_empty;
    addr_t      node_addr [NODES_NUM];
    logic [NODE_USAGE_W-1:0] node_usage [NODES_NUM];

    logic  arb_enable;
    logic  running;
    logic  run_end;
    word_t beat_word;

    // Run stays alive while any node has offsets left
    logic  any_pending;

    assign any_pending  = |node_pending;
    assign node_valid_o = ~node_empty;

    for (genvar i = 0; i < NODES_NUM; i++) begin : gen_node
        node_addr_gen u_node_addr_gen (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .base_addr_i  (base_addr_i[i]),
            .size_i       (size_i[i]),
            .stride_i     (stride_i[i]),
            .fifo_usage_i (node_usage[i]),
            .grant_i      (node_grant[i]),
            .run_end_i    (run_end),
            .running_i    (running),
            .request_o    (node_request[i]),
            .pending_o    (node_pending[i]),
            .rd_addr_o    (node_addr[i])
        );

        sync_fifo #(
            .DEPTH (NODE_FIFO_DEPTH),
            .WIDTH (WORD_W)
        ) u_node_fifo (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .push_i  (node_push[i]),
            .pop_i   (node_valid_o[i] & node_ready_i[i]),
            .data_i  (beat_word),
            .data_o  (node_data_o[i]),
            .full_o  (),
            .empty_o (node_empty[i]),
            .usage_o (node_usage[i])
        );
    end

    rr_arbiter u_rr_arbiter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .request_i (node_request),
        .enable_i  (arb_enable),
        .grant_o   (node_grant)
    );

    read_channel_ctrl u_read_channel_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .execute_i     (execute_i),
        .any_request_i (any_pending),
        .grant_i       (node_grant),
        .node_addr_i   (node_addr),
        .arb_enable_o  (arb_enable),
        .running_o     (running),
        .run_end_o     (run_end),
        .busy_o        (busy_o),
        .m_ar_addr_o   (m_ar_addr_o),
        .m_ar_valid_o  (m_ar_valid_o),
        .m_ar_ready_i  (m_ar_ready_i),
        .m_r_data_i    (m_r_data_i),
        .m_r_valid_i   (m_r_valid_i),
        .beat_word_o   (beat_word),
        .node_push_o   (node_push)
    );

endmodule

/* testbench/cgra_read_dma_assert.sv */
module cgra_read_dma_assert import cgra_rd_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  node_mask_t grant_i,
    input  addr_t      ar_addr_i,
    input  logic       ar_valid_i,
    input  logic       ar_ready_i,
    input  logic       r_valid_i,
    input  node_mask_t push_i,
    input  logic       busy_i
);

    int unsigned grant_fails = 0;
    int unsigned hold_fails  = 0;
    int unsigned push_fails  = 0;
    int unsigned idle_fails  = 0;

    // Failures over all assertions
    int unsigned fail_count;

    assign fail_count = grant_fails + hold_fails + push_fails + idle_fails;

    grant_one_hot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(grant_i))
    else begin
        $error("Arbiter grant is not one-hot: %b", grant_i);
        grant_fails++;
    end

    // Pending address must not move until the slave takes it
    addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin
        $error("Read address changed or dropped before ready");
        hold_fails++;
    end

    beat_one_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i |-> $onehot(push_i))
    else begin
        $error("Read beat pushed into %b", push_i);
        push_fails++;
    end

    push_in_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
        |push_i |-> busy_i)
    else begin
        $error("Node FIFO pushed while no run is active");
        idle_fails++;
    end

endmodule

bind read_channel_ctrl cgra_read_dma_assert u_cgra_read_dma_assert (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .grant_i    (grant_i),
    .ar_addr_i  (m_ar_addr_o),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_i (m_ar_ready_i),
    .r_valid_i  (m_r_valid_i),
    .push_i     (node_push_o),
    .busy_i     (busy_o)
);

/* testbench/cgra_read_dma_checker.sv */
module cgra_read_dma_checker import cgra_rd_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        execute_i,
    input  logic        busy_i,
    input  logic        run_done_i,
    input  addr_t       base_addr_i [NODES_NUM],
    input  len_t        size_i [NODES_NUM],
    input  len_t        stride_i [NODES_NUM],
    input  word_t       node_data_i [NODES_NUM],
    input  node_mask_t  node_valid_i,
    input  node_mask_t  node_ready_i,
    output int unsigned mismatch_count_o,
    output int unsigned missing_count_o
);

    int unsigned recv_count [NODES_NUM] = '{default: 0};
    int unsigned mismatch_q = 0;
    int unsigned missing_q  = 0;
    logic        exec_seen  = 1'b0;

    assign mismatch_count_o = mismatch_q;
    assign missing_count_o  = missing_q;

    // A partial last step below size still yields a word
    function automatic int unsigned words_in_run(len_t size, len_t stride);
        if (stride == '0) begin
            return 0;
        end
        return (32'(size) + 32'(stride) - 1) / 32'(stride);
    endfunction

    // Sampled on the falling edge, where inputs and outputs are settled
    always @(negedge clk_i) begin
        addr_t       exp_addr;
        word_t       exp_word;
        int unsigned want;
        if (rst_ni) begin
            if (exec_seen && !busy_i) begin
                $display("FAILED %0t: busy_o did not rise after execute_i", $time);
                mismatch_q++;
            end
            exec_seen = execute_i && !busy_i;
            if (exec_seen) begin
                for (int unsigned i = 0; i < NODES_NUM; i++) begin
                    recv_count[i] = 0;
                end
            end
            for (int unsigned i = 0; i < NODES_NUM; i++) begin
                if (node_valid_i[i] && node_ready_i[i]) begin
                    want = words_in_run(size_i[i], stride_i[i]);
                    exp_addr = base_addr_i[i] + recv_count[i] * 32'(stride_i[i]);
                    exp_word = exp_addr ^ 32'hC0DE0000;
                    if (recv_count[i] >= want) begin
                        $display("FAILED %0t: node %0d got extra word %h",
                                 $time, i, node_data_i[i]);
                        mismatch_q++;
                    end else if (node_data_i[i] !== exp_word) begin
                        $display("FAILED %0t: node %0d word %0d is %h, expected %h",
                                 $time, i, recv_count[i], node_data_i[i], exp_word);
                        mismatch_q++;
                    end
                    recv_count[i]++;
                end
            end
            if (run_done_i) begin
                for (int unsigned i = 0; i < NODES_NUM; i++) begin
                    want = words_in_run(size_i[i], stride_i[i]);
                    if (recv_count[i] < want) begin
                        $display("Node %0d received only %0d of its %0d words",
                                 i, recv_count[i], want);
                        missing_q += want - recv_count[i];
                    end
                end
            end
        end
    end

endmodule

/* testbench/tb_cgra_read_dma.sv */
module tb_cgra_read_dma import cgra_rd_pkg::*; ();

    logic       clk;
    logic       rst_n;
    logic       execute;
    logic       busy;
    logic       run_done;
    addr_t      base_addr [NODES_NUM];
    len_t       size [NODES_NUM];
    len_t       stride [NODES_NUM];
    word_t      node_data [NODES_NUM];
    node_mask_t node_valid;
    node_mask_t node_ready = '0;
    addr_t      ar_addr;
    logic       ar_valid;
    logic       ar_ready = 1'b0;
    bus_t       r_data = '0;
    logic       r_valid = 1'b0;

    int          seed = 32'h937e2f4c;
    int unsigned timeout_cycles = 0;
    int unsigned mismatch_count;
    int unsigned missing_count;
    int unsigned assert_fails;

    // Accepted addresses are answered in order by the slave model
    addr_t       ar_queue [$];
    int unsigned r_gap = 0;

    // Word 0 holds the test count and 12 words per test follow
    logic [31:0] test_mem [256];

    cgra_read_dma u_cgra_read_dma (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .execute_i    (execute),
        .busy_o       (busy),
        .base_addr_i  (base_addr),
        .size_i       (size),
        .stride_i     (stride),
        .node_data_o  (node_data),
        .node_valid_o (node_valid),
        .node_ready_i (node_ready),
        .m_ar_addr_o  (ar_addr),
        .m_ar_valid_o (ar_valid),
        .m_ar_ready_i (ar_ready),
        .m_r_data_i   (r_data),
        .m_r_valid_i  (r_valid)
    );

    cgra_read_dma_checker u_checker (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .execute_i        (execute),
        .busy_i           (busy),
        .run_done_i       (run_done),
        .base_addr_i      (base_addr),
        .size_i           (size),
        .stride_i         (stride),
        .node_data_i      (node_data),
        .node_valid_i     (node_valid),
        .node_ready_i     (node_ready),
        .mismatch_count_o (mismatch_count),
        .missing_count_o  (missing_count)
    );

    assign assert_fails = u_cgra_read_dma.u_read_channel_ctrl.u_cgra_read_dma_assert.fail_count;

    function automatic word_t mem_word(addr_t addr);
        return addr ^ 32'hC0DE0000;
    endfunction

    function automatic int unsigned words_in_run(len_t size_v, len_t stride_v);
        if (stride_v == '0) begin
            return 0;
        end
        return (32'(size_v) + 32'(stride_v) - 1) / 32'(stride_v);
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Address capture at the falling edge, where valid and ready are settled
    always @(negedge clk) begin
        if (rst_n && ar_valid && ar_ready) begin
            ar_queue.push_back(ar_addr);
        end
    end

    // Random ready on both sides and in-order beats with a short gap
    always @(posedge clk) begin
        addr_t beat_addr;
        #1;
        // Consumer takes a word on about one cycle in 16 per node
        node_ready = node_mask_t'($random(seed) & $random(seed) & $random(seed)
                                  & $random(seed));
        ar_ready   = ($random(seed) & 3) != 0;
        if (ar_queue.size() != 0 && r_gap == 0) begin
            beat_addr = ar_queue.pop_front();
            r_data    = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
            r_valid   = 1'b1;
            r_gap     = $random(seed) & 3;
        end else begin
            r_valid = 1'b0;
            if (r_gap != 0) begin
                r_gap--;
            end
        end
    end

    task automatic run_line(input int unsigned first);
        for (int unsigned n = 0; n < NODES_NUM; n++) begin
            base_addr[n] = test_mem[first + 3*n];
            size[n]      = len_t'(test_mem[first + 3*n + 1]);
            stride[n]    = len_t'(test_mem[first + 3*n + 2]);
        end
        execute = 1'b1;
        @(posedge clk);
        #1;
        execute = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (busy);
        // Let the consumer drain what is left in the node FIFOs
        while (node_valid != '0) begin
            @(posedge clk);
            #1;
        end
        run_done = 1'b1;
        @(posedge clk);
        #1;
        run_done = 1'b0;
    endtask

    initial begin
        int unsigned num_tests;
        int unsigned total;
        int unsigned words;
        rst_n    = 1'b0;
        execute  = 1'b0;
        run_done = 1'b0;
        for (int unsigned n = 0; n < NODES_NUM; n++) begin
            base_addr[n] = '0;
            size[n]      = '0;
            stride[n]    = '0;
        end
        $readmemh("testbench/dma_input.txt", test_mem);
        num_tests = test_mem[0];
        // Each line runs twice
        total = 0;
        for (int unsigned t = 0; t < num_tests; t++) begin
            words = 0;
            for (int unsigned n = 0; n < NODES_NUM; n++) begin
                words += words_in_run(len_t'(test_mem[1 + 12*t + 3*n + 1]),
                                      len_t'(test_mem[1 + 12*t + 3*n + 2]));
            end
            total += 2 * (40 * words + 200);
        end
        timeout_cycles = total;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int unsigned t = 0; t < num_tests; t++) begin
            // Second pass shows the offsets went back to zero
            run_line(1 + 12*t);
            run_line(1 + 12*t);
        end
        @(posedge clk);
        $display("Errors: %0d wrong values, %0d missing words, %0d assertion failures",
                 mismatch_count, missing_count, assert_fails);
        if (mismatch_count + missing_count + assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, a run did not finish", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

/* testbench/dma_input.txt */
// First word: number of test lines that follow
// Each line: base size stride for node 0, then node 1, node 2, node 3
4
// Stride 8, all nodes busy, node 2 size not a multiple of the stride
00001000 0020 0008  00002000 0040 0008  00003000 001C 0008  00004000 0030 0008
// Strides 4 and 12 reach both halves of the beat
00005004 0040 0004  00006000 0048 000C  00007004 0030 000C  00008000 0020 0004
// Nodes 0 and 2 have size 0
00009000 0000 0008  0000A004 0028 0004  0000B000 0000 0004  0000C008 0060 0010
// Long runs, node FIFOs fill under back-pressure
00010000 0100 0004  00020004 0100 0008  00030000 00C0 000C  00040008 0080 0004

/* project.f */
src/cgra_rd_pkg.sv
src/rr_arbiter.sv
src/node_addr_gen.sv
src/sync_fifo.sv
src/read_channel_ctrl.sv
src/cgra_read_dma.sv
testbench/cgra_read_dma_assert.sv
testbench/cgra_read_dma_checker.sv
testbench/tb_cgra_read_dma.sv

/* Makefile */
TOP := tb_cgra_read_dma

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
